// ==== source/kcpu_settings.svh ====
/* kcpu core settings
   data widths, CC flag positions, transfer codes and push mask bits */
`ifndef KCPU_SETTINGS_SVH
`define KCPU_SETTINGS_SVH

`define KCPU_W8  8
`define KCPU_W16 16

`define CC_C 0
`define CC_V 1
`define CC_Z 2
`define CC_N 3

`define RC_A 3'd0
`define RC_B 3'd1
`define RC_X 3'd2
`define RC_Y 3'd3
`define RC_S 3'd4
`define RC_U 3'd5

`define MSK_CC 0
`define MSK_A  1
`define MSK_B  2
`define MSK_DP 3
`define MSK_X  4
`define MSK_Y  5
`define MSK_U  6

`endif

// ==== source/kcpu_pkg.sv ====
/* kcpu shared types
   operation codes, postbyte decoding and the structs passed between blocks */
`include "kcpu_settings.svh"

package kcpu_pkg;

    typedef enum logic [4:0] {
        NOP,
        LDA, LDB, LDD, LDX, LDY, LDU, LDS, LDDP,
        ADDA, SUBA, ANDA, ORA, EORA, INCA, DECA,
        ADDD, SUBD,
        TFR, EXG,
        PSHS, PULS
    } op_e;

    // TFR/EXG register pair or PSHS/PULS list, same byte
    typedef union packed {
        struct packed {
            logic       pad_hi;
            logic [2:0] dst;
            logic       pad_lo;
            logic [2:0] src;
        } reg_pair;
        logic [`KCPU_W8-1:0] reg_mask;
    } postbyte_u;

    typedef struct packed {
        op_e                  op;
        logic [`KCPU_W16-1:0] operand;
        postbyte_u            post;
    } exec_cmd_t;

    typedef struct packed {
        logic [`KCPU_W8-1:0]  a;
        logic [`KCPU_W8-1:0]  b;
        logic [`KCPU_W8-1:0]  dp;
        logic [`KCPU_W8-1:0]  cc;
        logic [`KCPU_W16-1:0] x;
        logic [`KCPU_W16-1:0] y;
        logic [`KCPU_W16-1:0] u;
        logic [`KCPU_W16-1:0] s;
    } reg_view_t;

    typedef struct packed {
        logic [`KCPU_W16-1:0] value;
        logic [`KCPU_W8-1:0]  cc;
    } alu_res_t;

    typedef struct packed {
        logic [6:0] pull_sel;   // one-hot, mask bit order
        logic       hihalf;
        logic       dec_s;
        logic       inc_s;
        logic       last;
        logic       active;
    } stack_step_t;

endpackage

// ==== source/kcpu_alu.sv ====
/* kcpu ALU
   8-bit ops on A and 16-bit add/sub on D, with N Z V C generation */
`include "kcpu_settings.svh"

module kcpu_alu import kcpu_pkg::*; (
    input  op_e                  op,
    input  logic [`KCPU_W16-1:0] operand,
    input  reg_view_t            view,
    output alu_res_t             res
);

logic [`KCPU_W16-1:0] d;
logic [`KCPU_W8-1:0]  opb;    // operand low byte
logic [`KCPU_W8:0]    r9;     // 8-bit result plus carry
logic [`KCPU_W16:0]   r17;    // 16-bit result plus carry
logic                 wide;

assign d   = {view.a, view.b};
assign opb = operand[`KCPU_W8-1:0];

always_comb begin
    r9     = {1'b0, view.a};
    r17    = {1'b0, d};
    wide   = 1'b0;
    res.cc = view.cc;
    case (op)
        ADDA: begin
            r9 = {1'b0, view.a} + {1'b0, opb};
            res.cc[`CC_C] = r9[8];
            res.cc[`CC_V] = (view.a[7] == opb[7]) && (r9[7] != view.a[7]);
        end
        SUBA: begin
            r9 = {1'b0, view.a} - {1'b0, opb};
            res.cc[`CC_C] = r9[8];    // borrow
            res.cc[`CC_V] = (view.a[7] != opb[7]) && (r9[7] != view.a[7]);
        end
        ANDA: begin
            r9 = {1'b0, view.a & opb};
            res.cc[`CC_V] = 1'b0;
        end
        ORA: begin
            r9 = {1'b0, view.a | opb};
            res.cc[`CC_V] = 1'b0;
        end
        EORA: begin
            r9 = {1'b0, view.a ^ opb};
            res.cc[`CC_V] = 1'b0;
        end
        INCA: begin
            r9 = {1'b0, view.a + 8'd1};
            res.cc[`CC_V] = view.a == 8'h7f;
        end
        DECA: begin
            r9 = {1'b0, view.a - 8'd1};
            res.cc[`CC_V] = view.a == 8'h80;
        end
        ADDD: begin
            wide = 1'b1;
            r17  = {1'b0, d} + {1'b0, operand};
            res.cc[`CC_C] = r17[16];
            res.cc[`CC_V] = (d[15] == operand[15]) && (r17[15] != d[15]);
        end
        SUBD: begin
            wide = 1'b1;
            r17  = {1'b0, d} - {1'b0, operand};
            res.cc[`CC_C] = r17[16];
            res.cc[`CC_V] = (d[15] != operand[15]) && (r17[15] != d[15]);
        end
        default: ;
    endcase
    if (wide) begin
        res.value     = r17[`KCPU_W16-1:0];
        res.cc[`CC_N] = r17[15];
        res.cc[`CC_Z] = r17[`KCPU_W16-1:0] == '0;
    end else begin
        res.value     = {8'h00, r9[`KCPU_W8-1:0]};
        res.cc[`CC_N] = r9[7];
        res.cc[`CC_Z] = r9[`KCPU_W8-1:0] == '0;
    end
end

endmodule

// ==== source/kcpu_regs.sv ====
/* kcpu register file
   loads, ALU writeback, TFR/EXG, pull writeback and S pointer updates */
`include "kcpu_settings.svh"

module kcpu_regs import kcpu_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_valid,
    input  exec_cmd_t           cmd,
    input  alu_res_t            alu,
    input  stack_step_t         step,
    input  logic [`KCPU_W8-1:0] mem_rdata,
    output reg_view_t           view,
    output logic                done
);

reg_view_t            nxt;
logic                 accept;
logic                 single;     // finishes at the accepting edge
logic [2:0]           src_code;
logic [2:0]           dst_code;
logic [`KCPU_W16-1:0] src_val;
logic [`KCPU_W16-1:0] dst_val;

// 8-bit registers read zero-extended
function automatic logic [`KCPU_W16-1:0] rd_code(input reg_view_t r, input logic [2:0] code);
    case (code)
        `RC_A:   return {8'h00, r.a};
        `RC_B:   return {8'h00, r.b};
        `RC_X:   return r.x;
        `RC_Y:   return r.y;
        `RC_S:   return r.s;
        `RC_U:   return r.u;
        default: return '0;    // codes 6 and 7
    endcase
endfunction

function automatic reg_view_t wr_code(input reg_view_t r, input logic [2:0] code,
                                      input logic [`KCPU_W16-1:0] v);
    reg_view_t o;
    o = r;
    case (code)
        `RC_A:   o.a = v[`KCPU_W8-1:0];   // low byte only
        `RC_B:   o.b = v[`KCPU_W8-1:0];
        `RC_X:   o.x = v;
        `RC_Y:   o.y = v;
        `RC_S:   o.s = v;
        `RC_U:   o.u = v;
        default: ;
    endcase
    return o;
endfunction

// flags after a load, V cleared and C kept
function automatic logic [`KCPU_W8-1:0] ld_cc(input logic [`KCPU_W8-1:0] cc,
                                              input logic [`KCPU_W16-1:0] v, input logic wide);
    logic [`KCPU_W8-1:0] o;
    o = cc;
    o[`CC_N] = wide ? v[15] : v[7];
    o[`CC_Z] = wide ? (v == '0) : (v[`KCPU_W8-1:0] == '0);
    o[`CC_V] = 1'b0;
    return o;
endfunction

assign accept   = cmd_valid && !step.active;    // ignored while the stack runs
assign single   = !((cmd.op == PSHS || cmd.op == PULS) && cmd.post.reg_mask[6:0] != '0);
assign src_code = cmd.post.reg_pair.src;
assign dst_code = cmd.post.reg_pair.dst;
assign src_val  = rd_code(view, src_code);
assign dst_val  = rd_code(view, dst_code);

always_comb begin
    nxt = view;
    if (accept) begin
        case (cmd.op)
            LDA: begin
                nxt.a  = cmd.operand[`KCPU_W8-1:0];
                nxt.cc = ld_cc(view.cc, cmd.operand, 1'b0);
            end
            LDB: begin
                nxt.b  = cmd.operand[`KCPU_W8-1:0];
                nxt.cc = ld_cc(view.cc, cmd.operand, 1'b0);
            end
            LDDP: begin
                nxt.dp = cmd.operand[`KCPU_W8-1:0];
                nxt.cc = ld_cc(view.cc, cmd.operand, 1'b0);
            end
            LDD: begin
                {nxt.a, nxt.b} = cmd.operand;
                nxt.cc = ld_cc(view.cc, cmd.operand, 1'b1);
            end
            LDX, LDY, LDU, LDS: begin
                nxt    = wr_code(view, cmd.op == LDX ? `RC_X : cmd.op == LDY ? `RC_Y :
                                       cmd.op == LDU ? `RC_U : `RC_S, cmd.operand);
                nxt.cc = ld_cc(view.cc, cmd.operand, 1'b1);
            end
            ADDA, SUBA, ANDA, ORA, EORA, INCA, DECA: begin
                nxt.a  = alu.value[`KCPU_W8-1:0];
                nxt.cc = alu.cc;
            end
            ADDD, SUBD: begin
                {nxt.a, nxt.b} = alu.value;
                nxt.cc = alu.cc;
            end
            TFR: nxt = wr_code(view, dst_code, src_val);
            EXG: nxt = wr_code(wr_code(view, dst_code, src_val), src_code, dst_val);
            default: ;
        endcase
    end
    if (step.active) begin
        if (step.dec_s) nxt.s = view.s - 16'd1;
        if (step.inc_s) nxt.s = view.s + 16'd1;
        if (step.pull_sel[`MSK_CC]) nxt.cc = mem_rdata;
        if (step.pull_sel[`MSK_A])  nxt.a  = mem_rdata;
        if (step.pull_sel[`MSK_B])  nxt.b  = mem_rdata;
        if (step.pull_sel[`MSK_DP]) nxt.dp = mem_rdata;
        // 16-bit registers, one half per step
        if (step.pull_sel[`MSK_X]) begin
            if (step.hihalf) nxt.x[15:8] = mem_rdata;
            else             nxt.x[7:0]  = mem_rdata;
        end
        if (step.pull_sel[`MSK_Y]) begin
            if (step.hihalf) nxt.y[15:8] = mem_rdata;
            else             nxt.y[7:0]  = mem_rdata;
        end
        if (step.pull_sel[`MSK_U]) begin
            if (step.hihalf) nxt.u[15:8] = mem_rdata;
            else             nxt.u[7:0]  = mem_rdata;
        end
    end
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        view <= '0;
        done <= 1'b0;
    end else begin
        view <= nxt;
        done <= accept && single;
    end
end

endmodule

// ==== source/kcpu_stack_seq.sv ====
/* kcpu stack sequencer
   walks a PSHS/PULS register list one byte per cycle over the memory port */
`include "kcpu_settings.svh"

module kcpu_stack_seq import kcpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_valid,
    input  exec_cmd_t            cmd,
    input  reg_view_t            view,
    output stack_step_t          step,
    output logic                 mem_we,
    output logic [`KCPU_W16-1:0] mem_addr,
    output logic [`KCPU_W8-1:0]  mem_wdata,
    output logic                 busy,
    output logic                 done
);

logic [6:0]           mask;      // registers still to move
logic                 pull;
logic                 second;    // on the second byte of a 16-bit register
logic [6:0]           sel;
logic                 wide;
logic                 hihalf;
logic                 reg_end;   // this byte finishes the selected register
logic                 start;
logic [`KCPU_W16-1:0] wsrc;

assign start = cmd_valid && !busy && (cmd.op == PSHS || cmd.op == PULS)
             && cmd.post.reg_mask[6:0] != '0;

always_comb begin
    sel = '0;
    if (pull) begin
        sel = mask & (~mask + 7'd1);    // lowest bit, CC first
    end else begin
        for (int i = 0; i < 7; i++) begin
            if (mask[i]) sel = 7'd1 << i;    // highest bit wins
        end
    end
end

assign wide    = sel[`MSK_X] | sel[`MSK_Y] | sel[`MSK_U];
assign hihalf  = wide && (pull ^ second);    // push low first, pull high first
assign reg_end = !wide || second;

always_comb begin
    case (1'b1)
        sel[`MSK_U]:  wsrc = view.u;
        sel[`MSK_Y]:  wsrc = view.y;
        sel[`MSK_X]:  wsrc = view.x;
        sel[`MSK_DP]: wsrc = {8'h00, view.dp};
        sel[`MSK_B]:  wsrc = {8'h00, view.b};
        sel[`MSK_A]:  wsrc = {8'h00, view.a};
        default:      wsrc = {8'h00, view.cc};
    endcase
end

assign mem_wdata = hihalf ? wsrc[15:8] : wsrc[7:0];
assign mem_we    = busy && !pull;
assign mem_addr  = pull ? view.s : view.s - 16'd1;

assign step.pull_sel = (busy && pull) ? sel : '0;
assign step.hihalf   = hihalf;
assign step.dec_s    = busy && !pull;
assign step.inc_s    = busy && pull;
assign step.last     = busy && reg_end && (mask & ~sel) == '0;
assign step.active   = busy;

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        busy   <= 1'b0;
        done   <= 1'b0;
        mask   <= '0;
        pull   <= 1'b0;
        second <= 1'b0;
    end else begin
        done <= 1'b0;
        if (start) begin
            busy   <= 1'b1;
            mask   <= cmd.post.reg_mask[6:0];    // bit 7 has no register
            pull   <= cmd.op == PULS;
            second <= 1'b0;
        end else if (busy) begin
            if (reg_end) begin
                mask   <= mask & ~sel;
                second <= 1'b0;
            end else begin
                second <= 1'b1;
            end
            if (step.last) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end
end

endmodule

// ==== source/kcpu_exec.sv ====
/* kcpu execution core top
   joins the register file, ALU and stack sequencer */
`include "kcpu_settings.svh"

module kcpu_exec import kcpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_valid,
    input  exec_cmd_t            cmd,
    input  logic [`KCPU_W8-1:0]  mem_rdata,
    output logic                 mem_we,
    output logic [`KCPU_W16-1:0] mem_addr,
    output logic [`KCPU_W8-1:0]  mem_wdata,
    output logic                 busy,
    output logic                 done,
    output reg_view_t            regs
);

alu_res_t    alu;
stack_step_t step;
logic        regs_done;    // single-cycle commands
logic        seq_done;     // end of a push or pull list

kcpu_regs u_regs (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .alu       (alu),
    .step      (step),
    .mem_rdata (mem_rdata),
    .view      (regs),
    .done      (regs_done)
);

kcpu_alu u_alu (
    .op      (cmd.op),
    .operand (cmd.operand),
    .view    (regs),
    .res     (alu)
);

kcpu_stack_seq u_seq (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .view      (regs),
    .step      (step),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .busy      (busy),
    .done      (seq_done)
);

assign done = regs_done | seq_done;

endmodule

// ==== test/kcpu_model.svh ====
/* kcpu reference model
   architectural state, stack memory and the expected result of each command */
`ifndef KCPU_MODEL_SVH
`define KCPU_MODEL_SVH

reg_view_t  m_st;
logic [7:0] m_mem [0:65535];

// model register index 0..7 is a, b, dp, cc, x, y, u, s
localparam int code_map [0:5] = '{0, 1, 4, 5, 7, 6};
localparam int mask_map [0:6] = '{3, 0, 1, 2, 4, 5, 6};

function automatic logic [7:0] fill_byte(input int a);
    return a[15:8] ^ a[7:0] ^ 8'h3c;
endfunction

function automatic void model_reset();
    m_st = '0;
    for (int i = 0; i < 65536; i++) m_mem[i] = fill_byte(i);
endfunction

function automatic int byte_count(input exec_cmd_t c);
    int n;
    n = 0;
    for (int i = 0; i < 7; i++) begin
        if ((c.op == PSHS || c.op == PULS) && c.post.reg_mask[i]) n += (i >= `MSK_X) ? 2 : 1;
    end
    return n;
endfunction

function automatic logic [15:0] rd(input int r);
    case (r)
        0:       return {8'h00, m_st.a};
        1:       return {8'h00, m_st.b};
        2:       return {8'h00, m_st.dp};
        3:       return {8'h00, m_st.cc};
        4:       return m_st.x;
        5:       return m_st.y;
        6:       return m_st.u;
        default: return m_st.s;
    endcase
endfunction

function automatic void wr(input int r, input logic [15:0] v);
    case (r)
        0:       m_st.a = v[7:0];    // byte registers keep the low byte
        1:       m_st.b = v[7:0];
        2:       m_st.dp = v[7:0];
        3:       m_st.cc = v[7:0];
        4:       m_st.x = v;
        5:       m_st.y = v;
        6:       m_st.u = v;
        default: m_st.s = v;
    endcase
endfunction

function automatic void set_flags(input logic n, input logic z, input logic v, input logic c);
    m_st.cc[`CC_N] = n;
    m_st.cc[`CC_Z] = z;
    m_st.cc[`CC_V] = v;
    m_st.cc[`CC_C] = c;
endfunction

// integer arithmetic, overflow from the signed range
function automatic void alu_ref(input op_e op, input logic [15:0] k);
    logic        wide;
    logic [15:0] r;
    int          lim;
    int          xu, xs, ku, ks;
    int          ua, sa;
    wide = op == ADDD || op == SUBD;
    lim  = wide ? 32767 : 127;
    xu   = wide ? int'({m_st.a, m_st.b}) : int'(m_st.a);
    xs   = wide ? int'($signed({m_st.a, m_st.b})) : int'($signed(m_st.a));
    ku   = wide ? int'(k) : int'(k[7:0]);
    ks   = wide ? int'($signed(k)) : int'($signed(k[7:0]));
    case (op)
        ADDA, ADDD: ua = xu + ku;
        SUBA, SUBD: ua = xu - ku;
        INCA:       ua = xu + 1;
        DECA:       ua = xu - 1;
        ANDA:       ua = xu & ku;
        ORA:        ua = xu | ku;
        default:    ua = xu ^ ku;
    endcase
    case (op)
        ADDA, ADDD: sa = xs + ks;
        SUBA, SUBD: sa = xs - ks;
        INCA:       sa = xs + 1;
        DECA:       sa = xs - 1;
        default:    sa = 0;    // logic ops
    endcase
    r = wide ? ua[15:0] : {8'h00, ua[7:0]};
    set_flags(wide ? r[15] : r[7], r == 16'h0000, sa > lim || sa < -lim - 1,
              (op inside {ADDA, SUBA, ADDD, SUBD}) ? (ua < 0 || ua > 2 * lim + 1)
                                                   : m_st.cc[`CC_C]);
    if (wide) {m_st.a, m_st.b} = r;
    else m_st.a = r[7:0];
endfunction

function automatic void push_list(input logic [7:0] m);
    logic [15:0] v;
    for (int i = 6; i >= 0; i--) begin
        if (m[i]) begin
            v = rd(mask_map[i]);
            m_st.s -= 16'd1;
            m_mem[m_st.s] = v[7:0];
            if (i >= `MSK_X) begin
                m_st.s -= 16'd1;
                m_mem[m_st.s] = v[15:8];
            end
        end
    end
endfunction

function automatic void pull_list(input logic [7:0] m);
    logic [15:0] v;
    for (int i = 0; i < 7; i++) begin
        if (m[i]) begin
            v = {8'h00, m_mem[m_st.s]};
            m_st.s += 16'd1;
            if (i >= `MSK_X) begin
                v = {v[7:0], m_mem[m_st.s]};    // high byte came first
                m_st.s += 16'd1;
            end
            wr(mask_map[i], v);
        end
    end
endfunction

function automatic reg_view_t apply_cmd(input exec_cmd_t c);
    logic [2:0]  d;
    logic [2:0]  s;
    logic [15:0] dv;
    logic [15:0] sv;
    d  = c.post.reg_pair.dst;
    s  = c.post.reg_pair.src;
    sv = (s < 3'd6) ? rd(code_map[s]) : 16'h0000;    // codes 6 and 7 read zero
    dv = (d < 3'd6) ? rd(code_map[d]) : 16'h0000;
    case (c.op)
        LDA, LDB, LDDP: begin
            wr(c.op == LDA ? 0 : c.op == LDB ? 1 : 2, c.operand);
            set_flags(c.operand[7], c.operand[7:0] == 8'h00, 1'b0, m_st.cc[`CC_C]);
        end
        LDD, LDX, LDY, LDU, LDS: begin
            if (c.op == LDD) {m_st.a, m_st.b} = c.operand;
            else wr(c.op == LDX ? 4 : c.op == LDY ? 5 : c.op == LDU ? 6 : 7, c.operand);
            set_flags(c.operand[15], c.operand == 16'h0000, 1'b0, m_st.cc[`CC_C]);
        end
        ADDA, SUBA, ANDA, ORA, EORA, INCA, DECA, ADDD, SUBD: alu_ref(c.op, c.operand);
        TFR: if (d < 3'd6) wr(code_map[d], sv);
        EXG: begin
            if (d < 3'd6) wr(code_map[d], sv);
            if (s < 3'd6) wr(code_map[s], dv);
        end
        PSHS: push_list(c.post.reg_mask);
        PULS: pull_list(c.post.reg_mask);
        default: ;
    endcase
    return m_st;
endfunction

`endif

// ==== test/kcpu_exec_tb.sv ====
/* kcpu execution core testbench
   command stream against a reference model, byte memory on the stack port */
`include "kcpu_settings.svh"

module kcpu_exec_tb import kcpu_pkg::*; ();

logic        clk;
logic        rst;
logic        cmd_valid;
exec_cmd_t   cmd;
logic [7:0]  mem_rdata;
logic        mem_we;
logic [15:0] mem_addr;
logic [7:0]  mem_wdata;
logic        busy;
logic        done;
reg_view_t   regs;

logic [7:0]  mem [0:65535];
reg_view_t   exp_regs;
logic        exp_push;
int          exp_len;
string       cur_test;
integer      seed;
int          checks;
int          errors;
int          tests;
int          checks0;
int          errors0;

localparam op_e load_ops [0:7]   = '{LDA, LDB, LDD, LDX, LDY, LDU, LDS, LDDP};
localparam op_e alu_ops [0:8]    = '{ADDA, SUBA, ANDA, ORA, EORA, INCA, DECA, ADDD, SUBD};
localparam op_e code_loads [0:7] = '{LDA, LDB, LDX, LDY, LDS, LDU, NOP, NOP};
localparam op_e clr_ops [0:5]    = '{LDA, LDB, LDDP, LDX, LDY, LDU};
// load triples, alu pairs, transfer triples, stack rounds of 16 strobes
localparam int  n_cmds = 8 * 3 * 3 + 40 * 2 + 64 * 2 * 3 + 8 * 16;

`include "kcpu_model.svh"

kcpu_exec DUT (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .mem_rdata (mem_rdata),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .busy      (busy),
    .done      (done),
    .regs      (regs)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

assign mem_rdata = mem[mem_addr];    // asynchronous read

always @(posedge clk or posedge rst) begin
    if (rst) begin
        for (int i = 0; i < 65536; i++) mem[i] <= fill_byte(i);
    end else if (mem_we) begin
        mem[mem_addr] <= mem_wdata;
    end
end

function automatic logic [15:0] rand_word();
    int r;
    r = $random(seed);
    return r[15:0];
endfunction

function automatic int pick(input int n);
    int r;
    r = $random(seed) & 32'h7fffffff;
    return r % n;
endfunction

function automatic exec_cmd_t make_cmd(input op_e op, input logic [15:0] v, input logic [7:0] p);
    exec_cmd_t c;
    c = '0;
    c.op = op;
    c.operand = v;
    c.post.reg_mask = p;
    return c;
endfunction

task automatic begin_test(input string name);
    cur_test = name;
    checks0 = checks;
    errors0 = errors;
endtask

task automatic end_test();
    tests++;
    $display("test %s: %0d checks, %0d errors", cur_test, checks - checks0, errors - errors0);
endtask

// one command, optionally with a second strobe while the stack is busy
task automatic issue(input exec_cmd_t c, input logic inject);
    int        n;
    int        edges;
    exec_cmd_t extra;
    logic      exp_busy;
    logic      exp_we;
    n = byte_count(c);
    extra = make_cmd(LDA, 16'h00a5, 8'h00);
    @(posedge clk);
    #1;
    exp_regs = apply_cmd(c);
    exp_push = c.op == PSHS && n > 0;
    exp_len = n;
    cmd = c;
    cmd_valid = 1'b1;
    edges = 0;
    do begin
        @(posedge clk);
        edges++;
        #1;
        if (inject && edges == 1 && n > 0) begin
            cmd = extra;    // must be dropped
            cmd_valid = 1'b1;
        end else begin
            cmd_valid = 1'b0;
        end
        @(negedge clk);
        // busy from the accepting edge until the last byte has moved
        exp_busy = edges <= n;
        exp_we   = exp_busy && c.op == PSHS;
        checks++;
        assert (busy === exp_busy && mem_we === exp_we) else begin
            $display("FAIL %s busy mem_we after edge %0d of %s expected %b %b actual %b %b",
                     cur_test, edges, c.op.name(), exp_busy, exp_we, busy, mem_we);
            errors++;
        end
    end while (!done && edges < n + 3);
    checks++;
    assert (done) else begin
        $display("%s: no done within %0d cycles of %s", cur_test, n + 3, c.op.name());
        errors++;
    end
    if (done) begin
        assert (edges == n + 1) else begin
            $display("FAIL %s latency of %s expected %0d actual %0d",
                     cur_test, c.op.name(), n + 1, edges);
            errors++;
        end
    end
endtask

// compare at the falling edge of each done cycle
always @(negedge clk) begin
    logic [15:0] a;
    if (!rst && done) begin
        checks++;
        assert (regs === exp_regs) else begin
            $display("FAIL %s regs expected %h actual %h", cur_test, exp_regs, regs);
            errors++;
        end
        for (int i = 0; i < exp_len && exp_push; i++) begin
            a = exp_regs.s + i[15:0];
            checks++;
            assert (mem[a] === m_mem[a]) else begin
                $display("FAIL %s stack byte %h expected %h actual %h",
                         cur_test, a, m_mem[a], mem[a]);
                errors++;
            end
        end
    end
end

initial begin
    #((n_cmds * 20 + 10) * 10);
    $display("watchdog expired before the command stream finished");
    $display("Checks failed");
    $finish;
end

initial begin
    logic [15:0] w;
    logic [7:0]  m;
    seed = 1790;
    checks = 0;
    errors = 0;
    tests = 0;
    rst = 1'b1;
    cmd_valid = 1'b0;
    cmd = '0;
    exp_regs = '0;
    exp_push = 1'b0;
    exp_len = 0;
    model_reset();
    begin_test("reset");
    repeat (4) @(posedge clk);
    #1;
    checks++;
    assert (regs === '0 && !done && !busy && !mem_we) else begin
        $display("FAIL %s idle outputs expected %h 0 0 0 actual %h %b %b %b",
                 cur_test, 96'h0, regs, done, busy, mem_we);
        errors++;
    end
    rst = 1'b0;
    end_test();

    begin_test("loads");
    for (int i = 0; i < 8; i++) begin
        for (int j = 0; j < 3; j++) begin
            // 80h plus 80h leaves V and C set ahead of the load
            issue(make_cmd(LDA, 16'h0080, 8'h00), 1'b0);
            issue(make_cmd(ADDA, 16'h0080, 8'h00), 1'b0);
            w = (j == 0) ? 16'h0000 : (j == 1) ? 16'h8080 : rand_word();    // N set at either width
            issue(make_cmd(load_ops[i], w, 8'h00), 1'b0);
        end
    end
    end_test();

    begin_test("alu");
    repeat (40) begin
        issue(make_cmd(LDD, rand_word(), 8'h00), 1'b0);
        issue(make_cmd(alu_ops[pick(9)], rand_word(), 8'h00), 1'b0);
    end
    end_test();

    begin_test("transfer");
    for (int d = 0; d < 8; d++) begin
        for (int s = 0; s < 8; s++) begin
            for (int k = 0; k < 2; k++) begin
                issue(make_cmd(code_loads[d], rand_word(), 8'h00), 1'b0);
                issue(make_cmd(code_loads[s], rand_word(), 8'h00), 1'b0);
                issue(make_cmd(k == 0 ? TFR : EXG, 16'h0000,
                               {1'b0, d[2:0], 1'b0, s[2:0]}), 1'b0);
            end
        end
    end
    end_test();

    begin_test("stack");
    for (int r = 0; r < 8; r++) begin
        w = rand_word();
        m = (r == 0) ? 8'h80 : w[7:0];    // first list is empty
        for (int i = 0; i < 6; i++) issue(make_cmd(clr_ops[i], rand_word(), 8'h00), 1'b0);
        w = rand_word();
        issue(make_cmd(LDS, {2'b01, w[13:0]}, 8'h00), 1'b0);
        issue(make_cmd(PSHS, 16'h0000, m), 1'b0);
        for (int i = 0; i < 6; i++) issue(make_cmd(clr_ops[i], 16'h0000, 8'h00), 1'b0);
        issue(make_cmd(PULS, 16'h0000, m), 1'b1);
    end
    end_test();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
        $display("All checks passed");
    end else begin
        $display("Checks failed");
    end
    $finish;
end

endmodule

// ==== sim.f ====
+incdir+source
+incdir+test
source/kcpu_pkg.sv
source/kcpu_alu.sv
source/kcpu_regs.sv
source/kcpu_stack_seq.sv
source/kcpu_exec.sv
test/kcpu_exec_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module kcpu_exec_tb -Mdir obj_dir
	./obj_dir/Vkcpu_exec_tb | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
